// ==== src/mips_pkg.sv ====
// Shared encodings and field widths for the decode/execute pipeline slice, imported by every stage
`default_nettype none

package mips_pkg;

	// ----------------------------------------
	// Instruction format
	// ----------------------------------------
	localparam int INSTR_W = 32;  // Instruction word
	localparam int REG_AW  = 5;   // 32 registers
	localparam int IMM_W   = 16;  // I-type immediate

	// Primary opcode, bits 31:26
	typedef enum logic [5:0] {
		R_TYPE = 6'd0,
		ADDI   = 6'd8,
		SLTI   = 6'd10,
		ANDI   = 6'd12,
		ORI    = 6'd13
	} opcode_e;

	// R-type function code, bits 5:0
	typedef enum logic [5:0] {
		F_ADD = 6'd32,
		F_SUB = 6'd34,
		F_AND = 6'd36,
		F_OR  = 6'd37,
		F_NOR = 6'd39,
		F_SLT = 6'd42
	} funct_e;

	// ----------------------------------------
	// Decode to execute operation class
	// ----------------------------------------
	typedef enum logic [2:0] {
		ALU_OP_ADD   = 3'd0,  // ADDI
		ALU_OP_SLT   = 3'd1,  // SLTI
		ALU_OP_AND   = 3'd2,  // ANDI
		ALU_OP_OR    = 3'd3,  // ORI
		ALU_OP_RTYPE = 3'd4   // Look at funct
	} alu_op_e;

	// ALU function select
	typedef enum logic [3:0] {
		A_ADD  = 4'd0,
		A_SUB  = 4'd1,
		A_AND  = 4'd2,
		A_OR   = 4'd3,
		A_NOR  = 4'd4,
		A_SLT  = 4'd5,
		A_NONE = 4'd15  // Unknown funct, result 0 and no write
	} alu_ctrl_e;

endpackage

`default_nettype wire

// ==== src/alu.sv ====
// Combinational ALU for the execute stage: add, sub, and, or, nor and signed set-on-less-than
`default_nettype none
`timescale 1ns/10ps

module alu #(
	parameter int DATA_W = 32
) (
	input  logic [DATA_W-1:0]   op_1,
	input  logic [DATA_W-1:0]   op_2,
	input  mips_pkg::alu_ctrl_e alu_ctrl_code,
	output logic [DATA_W-1:0]   res,
	output logic                zero
);
	import mips_pkg::*;

	logic lt_signed;

	// Two's complement compare for SLT and SLTI
	assign lt_signed = $signed(op_1) < $signed(op_2);

	// ----------------------------------------
	// Function select
	// ----------------------------------------
	always_comb begin
		case (alu_ctrl_code)
			A_ADD:   res = op_1 + op_2;
			A_SUB:   res = op_1 - op_2;
			A_AND:   res = op_1 & op_2;
			A_OR:    res = op_1 | op_2;
			A_NOR:   res = ~(op_1 | op_2);
			A_SLT:   res = {{(DATA_W-1){1'b0}}, lt_signed};  // 1 or 0
			default: res = '0;  // A_NONE
		endcase
	end

	assign zero = (res == '0);  // High on an all-zero result

endmodule

`default_nettype wire

// ==== src/alu_ctrl.sv ====
// ALU control: turns the operation class and the R-type function code into an ALU function select
`default_nettype none
`timescale 1ns/10ps

module alu_ctrl (
	input  mips_pkg::alu_op_e   alu_op,
	input  logic [5:0]          fnc_code,
	output mips_pkg::alu_ctrl_e alu_ctrl_code
);
	import mips_pkg::*;

	always_comb begin
		case (alu_op)
			ALU_OP_ADD: alu_ctrl_code = A_ADD;  // ADDI
			ALU_OP_SLT: alu_ctrl_code = A_SLT;  // SLTI
			ALU_OP_AND: alu_ctrl_code = A_AND;  // ANDI
			ALU_OP_OR:  alu_ctrl_code = A_OR;   // ORI

			// R-type goes by function code
			ALU_OP_RTYPE: begin
				case (fnc_code)
					F_ADD:   alu_ctrl_code = A_ADD;
					F_SUB:   alu_ctrl_code = A_SUB;
					F_AND:   alu_ctrl_code = A_AND;
					F_OR:    alu_ctrl_code = A_OR;
					F_NOR:   alu_ctrl_code = A_NOR;
					F_SLT:   alu_ctrl_code = A_SLT;
					default: alu_ctrl_code = A_NONE;  // Execute drops the write
				endcase
			end

			default: alu_ctrl_code = A_NONE;
		endcase
	end

endmodule

`default_nettype wire

// ==== src/reg_file.sv ====
// 32-entry register file read by decode and written from EX/MEM, with write-through on a same-cycle hit
`default_nettype none
`timescale 1ns/10ps

module reg_file #(
	parameter int DATA_W = 32
) (
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic [mips_pkg::REG_AW-1:0] rd_addr_1,
	input  logic [mips_pkg::REG_AW-1:0] rd_addr_2,
	output logic [DATA_W-1:0]           rd_data_1,
	output logic [DATA_W-1:0]           rd_data_2,
	input  logic                        wr_en,
	input  logic [mips_pkg::REG_AW-1:0] wr_addr,
	input  logic [DATA_W-1:0]           wr_data
);
	import mips_pkg::*;

	localparam int N_REGS = 2**REG_AW;

	logic [DATA_W-1:0] regs [N_REGS];
	logic              wr_live;  // Write that really lands
	logic              byp_1;
	logic              byp_2;

	// Register zero never takes a write
	assign wr_live = wr_en && (wr_addr != '0);

	// ----------------------------------------
	// Write port
	// ----------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < N_REGS; i++) begin
				regs[i] <= '0;  // All registers read zero after reset
			end
		end else if (wr_live) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// ----------------------------------------
	// Read ports with write-through
	// ----------------------------------------
	assign byp_1 = wr_live && (wr_addr == rd_addr_1);
	assign byp_2 = wr_live && (wr_addr == rd_addr_2);

	assign rd_data_1 = byp_1 ? wr_data : regs[rd_addr_1];  // Same-cycle write wins
	assign rd_data_2 = byp_2 ? wr_data : regs[rd_addr_2];

	// Write-back address must be resolved whenever EX/MEM writes
	a_wr_addr_known: assert property (@(posedge clk) disable iff (!arst_n)
		wr_en |-> !$isunknown(wr_addr))
		else $error("reg_file: unknown write address with wr_en high");

endmodule

`default_nettype wire

// ==== src/id_decode.sv ====
// Decode stage: splits the instruction, reads operands, extends the immediate and loads the ID/EX register
`default_nettype none
`timescale 1ns/10ps

module id_decode #(
	parameter int DATA_W = 32
) (
	input  logic                         clk,
	input  logic                         arst_n,
	input  logic                         instr_valid,
	input  logic [mips_pkg::INSTR_W-1:0] instr,
	output logic [mips_pkg::REG_AW-1:0]  rd_addr_1,
	output logic [mips_pkg::REG_AW-1:0]  rd_addr_2,
	input  logic [DATA_W-1:0]            rd_data_1,
	input  logic [DATA_W-1:0]            rd_data_2,
	output logic                         id_valid,
	output logic [mips_pkg::REG_AW-1:0]  rs,
	output logic [mips_pkg::REG_AW-1:0]  rt,
	output logic [mips_pkg::REG_AW-1:0]  rd,
	output logic [DATA_W-1:0]            data_1,
	output logic [DATA_W-1:0]            data_2,
	output logic [DATA_W-1:0]            imm_ext,
	output logic                         reg_dst,
	output logic                         alu_src,
	output mips_pkg::alu_op_e            alu_op,
	output logic [5:0]                   fnc_code,
	output logic                         id_reg_write
);
	import mips_pkg::*;

	logic [IMM_W-1:0]  imm;
	logic [DATA_W-1:0] imm_next;
	logic              dec_reg_dst;   // 1 selects rd
	logic              dec_alu_src;   // 1 selects immediate
	logic              dec_sign_ext;
	logic              dec_reg_write;
	alu_op_e           dec_alu_op;

	assign rd_addr_1 = instr[25:21];  // rs
	assign rd_addr_2 = instr[20:16];  // rt
	assign imm       = instr[IMM_W-1:0];

	// ----------------------------------------
	// Control decode
	// ----------------------------------------
	always_comb begin
		dec_reg_dst   = 1'b0;
		dec_alu_src   = 1'b1;
		dec_sign_ext  = 1'b1;
		dec_reg_write = 1'b1;
		dec_alu_op    = ALU_OP_ADD;
		case (opcode_e'(instr[31:26]))
			R_TYPE: begin
				dec_reg_dst = 1'b1;
				dec_alu_src = 1'b0;
				dec_alu_op  = ALU_OP_RTYPE;
			end
			ADDI: dec_alu_op = ALU_OP_ADD;
			SLTI: dec_alu_op = ALU_OP_SLT;
			ANDI: begin
				dec_alu_op   = ALU_OP_AND;
				dec_sign_ext = 1'b0;  // Logical ops zero-extend
			end
			ORI: begin
				dec_alu_op   = ALU_OP_OR;
				dec_sign_ext = 1'b0;
			end
			default: dec_reg_write = 1'b0;  // Unknown opcode writes nothing
		endcase
	end

	assign imm_next = dec_sign_ext ? {{(DATA_W-IMM_W){imm[IMM_W-1]}}, imm}
	                               : {{(DATA_W-IMM_W){1'b0}}, imm};

	// ----------------------------------------
	// ID/EX register
	// ----------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			id_valid     <= 1'b0;
			id_reg_write <= 1'b0;
		end else begin
			id_valid     <= instr_valid;
			id_reg_write <= instr_valid && dec_reg_write;
		end
	end

	// Payload only moves on a new instruction
	always_ff @(posedge clk) begin
		if (instr_valid) begin
			rs       <= instr[25:21];
			rt       <= instr[20:16];
			rd       <= instr[15:11];
			data_1   <= rd_data_1;
			data_2   <= rd_data_2;
			imm_ext  <= imm_next;
			reg_dst  <= dec_reg_dst;
			alu_src  <= dec_alu_src;
			alu_op   <= dec_alu_op;
			fnc_code <= instr[5:0];
		end
	end

endmodule

`default_nettype wire

// ==== src/ex_stage.sv ====
// Execute stage: forwarding from EX/MEM, operand and destination select, ALU, and the EX/MEM register
`default_nettype none
`timescale 1ns/10ps

module ex_stage #(
	parameter int DATA_W = 32
) (
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic                        id_valid,
	input  logic [mips_pkg::REG_AW-1:0] rs,
	input  logic [mips_pkg::REG_AW-1:0] rt,
	input  logic [mips_pkg::REG_AW-1:0] rd,
	input  logic [DATA_W-1:0]           data_1,
	input  logic [DATA_W-1:0]           data_2,
	input  logic [DATA_W-1:0]           imm_ext,
	input  logic                        reg_dst,
	input  logic                        alu_src,
	input  mips_pkg::alu_op_e           alu_op,
	input  logic [5:0]                  fnc_code,
	input  logic                        id_reg_write,
	output logic                        ex_valid,
	output logic [DATA_W-1:0]           res,
	output logic                        zero,
	output logic [mips_pkg::REG_AW-1:0] write_register,
	output logic                        reg_write
);
	import mips_pkg::*;

	logic              fwd_ok;  // EX/MEM holds a live write
	logic [DATA_W-1:0] op_1;
	logic [DATA_W-1:0] reg_2;
	logic [DATA_W-1:0] op_2;
	logic [REG_AW-1:0] dest;
	logic [DATA_W-1:0] alu_res;
	logic              alu_zero;
	alu_ctrl_e         ctrl_code;

	// ----------------------------------------
	// Forwarding from EX/MEM
	// ----------------------------------------
	assign fwd_ok = ex_valid && reg_write && (write_register != '0);
	assign op_1   = (fwd_ok && write_register == rs) ? res : data_1;
	assign reg_2  = (fwd_ok && write_register == rt) ? res : data_2;

	assign op_2 = alu_src ? imm_ext : reg_2;  // Immediate for I-type
	assign dest = reg_dst ? rd : rt;          // rd for R-type

	alu_ctrl alu_ctrl_i (
		.alu_op        (alu_op),
		.fnc_code      (fnc_code),
		.alu_ctrl_code (ctrl_code)
	);

	alu #(.DATA_W(DATA_W)) alu_i (
		.op_1          (op_1),
		.op_2          (op_2),
		.alu_ctrl_code (ctrl_code),
		.res           (alu_res),
		.zero          (alu_zero)
	);

	// ----------------------------------------
	// EX/MEM register
	// ----------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_valid  <= 1'b0;
			reg_write <= 1'b0;
		end else begin
			ex_valid  <= id_valid;
			reg_write <= id_valid && id_reg_write && (ctrl_code != A_NONE);  // Unknown funct
		end
	end

	always_ff @(posedge clk) begin
		res            <= alu_res;
		zero           <= alu_zero;
		write_register <= dest;
	end

endmodule

`default_nettype wire

// ==== src/mips_ex_top.sv ====
// Top of the decode/execute slice: wires decode, execute and the register file, with EX/MEM write-back
`default_nettype none
`timescale 1ns/10ps

module mips_ex_top #(
	parameter int DATA_W = 32
) (
	input  logic                         clk,
	input  logic                         arst_n,
	input  logic                         instr_valid,
	input  logic [mips_pkg::INSTR_W-1:0] instr,
	output logic                         ex_valid,
	output logic [DATA_W-1:0]            res,
	output logic                         zero,
	output logic [mips_pkg::REG_AW-1:0]  write_register,
	output logic                         reg_write
);
	import mips_pkg::*;

	// Register file ports
	logic [REG_AW-1:0] rd_addr_1;
	logic [REG_AW-1:0] rd_addr_2;
	logic [DATA_W-1:0] rd_data_1;
	logic [DATA_W-1:0] rd_data_2;

	// ----------------------------------------
	// ID/EX
	// ----------------------------------------
	logic              id_valid;
	logic [REG_AW-1:0] rs;
	logic [REG_AW-1:0] rt;
	logic [REG_AW-1:0] rd;
	logic [DATA_W-1:0] data_1;
	logic [DATA_W-1:0] data_2;
	logic [DATA_W-1:0] imm_ext;
	logic              reg_dst;
	logic              alu_src;
	alu_op_e           alu_op;
	logic [5:0]        fnc_code;
	logic              id_reg_write;

	reg_file #(.DATA_W(DATA_W)) reg_file_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.rd_addr_1 (rd_addr_1),
		.rd_addr_2 (rd_addr_2),
		.rd_data_1 (rd_data_1),
		.rd_data_2 (rd_data_2),
		.wr_en     (ex_valid & reg_write),  // Write-back straight from EX/MEM
		.wr_addr   (write_register),
		.wr_data   (res)
	);

	id_decode #(.DATA_W(DATA_W)) id_decode_i (
		.clk          (clk),
		.arst_n       (arst_n),
		.instr_valid  (instr_valid),
		.instr        (instr),
		.rd_addr_1    (rd_addr_1),
		.rd_addr_2    (rd_addr_2),
		.rd_data_1    (rd_data_1),
		.rd_data_2    (rd_data_2),
		.id_valid     (id_valid),
		.rs           (rs),
		.rt           (rt),
		.rd           (rd),
		.data_1       (data_1),
		.data_2       (data_2),
		.imm_ext      (imm_ext),
		.reg_dst      (reg_dst),
		.alu_src      (alu_src),
		.alu_op       (alu_op),
		.fnc_code     (fnc_code),
		.id_reg_write (id_reg_write)
	);

	ex_stage #(.DATA_W(DATA_W)) ex_stage_i (
		.clk            (clk),
		.arst_n         (arst_n),
		.id_valid       (id_valid),
		.rs             (rs),
		.rt             (rt),
		.rd             (rd),
		.data_1         (data_1),
		.data_2         (data_2),
		.imm_ext        (imm_ext),
		.reg_dst        (reg_dst),
		.alu_src        (alu_src),
		.alu_op         (alu_op),
		.fnc_code       (fnc_code),
		.id_reg_write   (id_reg_write),
		.ex_valid       (ex_valid),
		.res            (res),
		.zero           (zero),
		.write_register (write_register),
		.reg_write      (reg_write)
	);

	// Two-stage latency end to end, both ways
	a_no_spurious_ex: assert property (@(posedge clk) disable iff (!arst_n)
		!instr_valid |-> ##2 !ex_valid)
		else $error("ex_valid without an instruction two edges earlier");

	a_result_on_time: assert property (@(posedge clk) disable iff (!arst_n)
		instr_valid |-> ##2 ex_valid)
		else $error("instruction did not reach EX/MEM after two edges");

endmodule

`default_nettype wire

// ==== verif/tb_mips_ex.sv ====
// Testbench for mips_ex_top: replays the instruction trace with random gaps and checks EX/MEM results
`timescale 1ns/10ps
`default_nettype none

module tb_mips_ex;

	localparam int DATA_W          = 32;
	localparam int TRACE_LEN       = 28;              // Instructions in the trace
	localparam int TRACE_COLS      = 5;               // instr, res, dest, zero, reg_write
	localparam int TRACE_WORDS     = TRACE_LEN * TRACE_COLS;
	localparam int WATCHDOG_CYCLES = TRACE_LEN * 6 + 50;

	logic              clk;
	logic              arst_n;
	logic              instr_valid;
	logic [31:0]       instr;
	logic              ex_valid;
	logic [DATA_W-1:0] res;
	logic              zero;
	logic [4:0]        write_register;
	logic              reg_write;

	logic [31:0] trace_mem [TRACE_WORDS];
	logic [15:0] lfsr;       // Gap generator state
	int          due_q [$];  // Negedge count at which each result is due
	int          neg_cnt;
	int          n_checked;

	mips_ex_top #(.DATA_W(DATA_W)) mips_ex_top_i (
		.clk            (clk),
		.arst_n         (arst_n),
		.instr_valid    (instr_valid),
		.instr          (instr),
		.ex_valid       (ex_valid),
		.res            (res),
		.zero           (zero),
		.write_register (write_register),
		.reg_write      (reg_write)
	);

	always #10 clk = ~clk;  // 20 ns period

	// ----------------------------------------
	// Helpers
	// ----------------------------------------
	// 16-bit Fibonacci LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// Draws 0 to 3 idle cycles before the next instruction
	task automatic draw_gap(output logic [1:0] gap);
		lfsr   = lfsr_step(lfsr);
		gap[0] = lfsr[0];
		lfsr   = lfsr_step(lfsr);  // One step per bit
		gap[1] = lfsr[0];
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
	                           input logic [31:0] expected);
		if (actual !== expected) begin
			abort_run($sformatf("** Error at %0d ns: %s is 0x%h, expected 0x%h",
			                    $time, name, actual, expected));
		end
	endtask

	// ----------------------------------------
	// Result checker on the falling edge
	// ----------------------------------------
	always @(negedge clk) begin
		neg_cnt++;
		if (!arst_n) begin
			check_value("ex_valid", 32'(ex_valid), 32'd0);  // Quiet in reset
		end else if (ex_valid) begin
			if (due_q.size() == 0) begin
				abort_run($sformatf("ex_valid high at %0d ns with no instruction in flight",
				                    $time));
			end else if (due_q[0] != neg_cnt) begin
				abort_run($sformatf("Result %0d arrived at cycle %0d instead of cycle %0d",
				                    n_checked, neg_cnt, due_q[0]));
			end else begin
				void'(due_q.pop_front());
				check_value($sformatf("res of entry %0d", n_checked), 32'(res),
				            trace_mem[n_checked*TRACE_COLS+1]);
				check_value($sformatf("write_register of entry %0d", n_checked),
				            32'(write_register), trace_mem[n_checked*TRACE_COLS+2]);
				check_value($sformatf("zero of entry %0d", n_checked), 32'(zero),
				            trace_mem[n_checked*TRACE_COLS+3]);
				check_value($sformatf("reg_write of entry %0d", n_checked), 32'(reg_write),
				            trace_mem[n_checked*TRACE_COLS+4]);
				n_checked++;
			end
		end else if (due_q.size() != 0 && due_q[0] <= neg_cnt) begin
			abort_run($sformatf("No ex_valid for entry %0d at cycle %0d", n_checked, neg_cnt));
		end
	end

	// ----------------------------------------
	// Stimulus
	// ----------------------------------------
	initial begin
		logic [1:0] gap;

		clk         = 1'b0;
		arst_n      = 1'b0;
		instr_valid = 1'b0;
		instr       = '0;
		lfsr        = 16'd3512;
		neg_cnt     = 0;
		n_checked   = 0;

		// Marker fill catches a short trace
		for (int k = 0; k < TRACE_WORDS; k++) begin
			trace_mem[k] = ~32'(k);
		end
		$readmemh("verif/ex_trace.txt", trace_mem);
		if (trace_mem[TRACE_WORDS-1] > 32'd1) begin
			abort_run("Trace file is missing or shorter than expected");
		end

		repeat (8) @(posedge clk);
		arst_n <= 1'b1;

		for (int i = 0; i < TRACE_LEN; i++) begin
			draw_gap(gap);
			repeat (gap) begin
				@(posedge clk);
				instr_valid <= 1'b0;
			end
			@(posedge clk);
			instr_valid <= 1'b1;
			instr       <= trace_mem[i*TRACE_COLS];
			due_q.push_back(neg_cnt + 3);  // Due at the negedge after the second edge from now
		end
		@(posedge clk);
		instr_valid <= 1'b0;

		wait (n_checked == TRACE_LEN);
		repeat (4) @(posedge clk);  // Room for a stray ex_valid

		$display("TEST PASSED");
		$finish;
	end

	// Watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		abort_run($sformatf("Watchdog expired after %0d cycles, %0d of %0d results checked",
		                    WATCHDOG_CYCLES, n_checked, TRACE_LEN));
	end

endmodule

`default_nettype wire

// ==== list.f ====
src/mips_pkg.sv
src/alu.sv
src/alu_ctrl.sv
src/reg_file.sv
src/id_decode.sv
src/ex_stage.sv
src/mips_ex_top.sv
verif/tb_mips_ex.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the decode/execute slice with Verilator and run its testbench

cd "$(dirname "$0")" || exit 1

LOG=sim.log
EXE=obj_dir/sim_mips_ex

verilator --binary --assert --timescale 1ns/10ps -j 0 \
	-f list.f --top-module tb_mips_ex -o sim_mips_ex
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"$EXE" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^TEST PASSED$" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// ==== verif/ex_trace.txt ====
// Columns are instr, expected res, dest register, zero flag, reg_write, all hex
// One instruction per line in issue order, results come back in the same order
20010005 00000005 01 0 1  // addi $1, $0, 5
2002FFFD FFFFFFFD 02 0 1  // addi $2, $0, -3
34038F0F 00008F0F 03 0 1  // ori $3, $0, 0x8f0f
3064F00F 0000800F 04 0 1  // andi $4, $3, 0xf00f
00222820 00000002 05 0 1  // add $5, $1, $2
00223022 00000008 06 0 1  // sub $6, $1, $2
00233824 00000005 07 0 1  // and $7, $1, $3
00434025 FFFFFFFF 08 0 1  // or $8, $2, $3
00234827 FFFF70F0 09 0 1  // nor $9, $1, $3
0041502A 00000001 0A 0 1  // slt $10, $2, $1
0022582A 00000000 0B 1 1  // slt $11, $1, $2
00216022 00000000 0C 1 1  // sub $12, $1, $1
284DFFFE 00000001 0D 0 1  // slti $13, $2, -2
200E0064 00000064 0E 0 1  // addi $14, $0, 100
01CE7820 000000C8 0F 0 1  // add $15, $14, $14
01EE7822 00000064 0F 0 1  // sub $15, $15, $14
21EF0001 00000065 0F 0 1  // addi $15, $15, 1
00210020 0000000A 00 0 1  // add $0, $1, $1
20100007 00000007 10 0 1  // addi $16, $0, 7
0022803F 00000000 10 1 0  // unknown funct 0x3f, rd $16
FC300004 00000009 10 0 0  // unknown opcode 0x3f, rt $16
02008820 00000007 11 0 1  // add $17, $16, $0
01E59025 00000067 12 0 1  // or $18, $15, $5
02489824 00000067 13 0 1  // and $19, $18, $8
0272A022 00000000 14 1 1  // sub $20, $19, $18
0120A82A 00000001 15 0 1  // slt $21, $9, $0
3016FFFF 00000000 16 1 1  // andi $22, $0, 0xffff
008DB820 00008010 17 0 1  // add $23, $4, $13
